//--- Bender.yml
package:
  name: elink

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/elink_pkg.sv
      - verilog/elink_mi_decode.sv
      - verilog/elink_cfg_regs.sv
      - verilog/elink_mailbox.sv
      - verilog/elink_top.sv
  - target: test
    include_dirs:
      - verilog
      - verification
    files:
      - verification/elink_tb.sv

//--- sim.f
+incdir+verilog
+incdir+verification
verilog/elink_pkg.sv
verilog/elink_mi_decode.sv
verilog/elink_cfg_regs.sv
verilog/elink_mailbox.sv
verilog/elink_top.sv
verification/elink_tb.sv

//--- verification/elink_tb_tasks.svh
`ifndef ELINK_TB_TASKS_SVH
`define ELINK_TB_TASKS_SVH

function automatic logic [`ELINK_RFAW-1:0] cfg_addr(input logic [7:0] ofs);
   return {`ELINK_BLK_CFG, ofs};                                 // Config block
endfunction

function automatic logic [`ELINK_RFAW-1:0] mbox_addr(input logic [7:0] ofs);
   return {`ELINK_BLK_MBOX, ofs};
endfunction

// One write strobe, driven on the falling edge
task automatic mi_write(input logic [`ELINK_RFAW-1:0] addr, input logic [`ELINK_DW-1:0] data);
   @(negedge mi_clk);
   mi_req = '{en: 1'b1, we: 1'b1, addr: addr, din: data};
   @(negedge mi_clk);
   mi_req = '0;
endtask

task automatic mi_read(input logic [`ELINK_RFAW-1:0] addr, output logic [`ELINK_DW-1:0] data);
   int waited;
   @(negedge mi_clk);
   mi_req = '{en: 1'b1, we: 1'b0, addr: addr, din: '0};
   @(negedge mi_clk);
   mi_req = '0;
   waited = 1;
   while (!mi_rd_valid && waited < 2) begin                      // Up to two cycles
      @(negedge mi_clk);
      waited++;
   end
   if (!mi_rd_valid) begin
      $display("Read of address %h got no response within two cycles", addr);
      stop_with_failure();
   end
   data = mi_rd_data;
endtask

task automatic push_entry(input logic [2*`ELINK_DW-1:0] entry);
   mi_write(mbox_addr(`EMBOX_LO_OFS), entry[`ELINK_DW-1:0]);     // Held low half
   mi_write(mbox_addr(`EMBOX_HI_OFS), entry[2*`ELINK_DW-1:`ELINK_DW]);
endtask

task automatic check_word(input string what, input logic [`ELINK_DW-1:0] got,
                          input logic [`ELINK_DW-1:0] exp_val);
   if (got !== exp_val) begin
      $display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp_val);
      stop_with_failure();
   end
endtask

task automatic check_ctrl(input string what, input ecfg_ctrl_t got, input ecfg_ctrl_t exp_val);
   if (got !== exp_val) begin
      $display("ERROR at %0t: %s, got %p, expected %p", $time, what, got, exp_val);
      stop_with_failure();
   end
endtask

task automatic check_status(input string what, input mbox_status_t got,
                            input mbox_status_t exp_val);
   if (got !== exp_val) begin
      $display("ERROR at %0t: %s, got full %b not_empty %b, expected full %b not_empty %b",
               $time, what, got.full, got.not_empty, exp_val.full, exp_val.not_empty);
      stop_with_failure();
   end
endtask

`endif

//--- verification/elink_tb.sv
`include "elink_defs.svh"

module elink_tb
   import elink_pkg::*;
();

   localparam int          WATCHDOG_CYCLES = 2000;              // Tests need about 120 cycles
   localparam logic [31:0] SEED            = 32'h8717_aa9b;
   localparam logic [`ELINK_RFAW-1:0] UNMAPPED_ADDR = {5'd3, `ECFG_COREID_OFS};  // Block 3

   logic                 mi_clk;
   logic                 rst;
   mi_req_t              mi_req;
   logic [`ELINK_DW-1:0] mi_rd_data;
   logic                 mi_rd_valid;
   ecfg_ctrl_t           ctrl;
   logic                 resetb_out;
   logic                 embox_full;
   logic                 embox_not_empty;
   mbox_status_t         flags;                                 // Flag pins as one struct
   ecfg_ctrl_t           exp_ctrl;                              // Expected control fields

   assign flags.full      = embox_full;
   assign flags.not_empty = embox_not_empty;

   elink_top i_elink_top (
      .mi_clk          (mi_clk),
      .rst             (rst),
      .mi_req          (mi_req),
      .mi_rd_data      (mi_rd_data),
      .mi_rd_valid     (mi_rd_valid),
      .ctrl            (ctrl),
      .resetb_out      (resetb_out),
      .embox_full      (embox_full),
      .embox_not_empty (embox_not_empty)
   );

   task automatic stop_with_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at the first failure");
   endtask

   `include "elink_tb_tasks.svh"

   task automatic test_reset_values();
      logic [31:0] rd;
      exp_ctrl        = '0;
      exp_ctrl.coreid = 12'h810;                                 // Only nonzero field
      check_ctrl("ctrl after reset", ctrl, exp_ctrl);
      check_word("resetb_out after reset", 32'(resetb_out), 32'd1);
      check_status("flags after reset", flags, '0);
      mi_read(cfg_addr(`ECFG_COREID_OFS), rd);
      check_word("COREID after reset", rd, 32'h0000_0810);
      mi_read(cfg_addr(`ECFG_VERSION_OFS), rd);
      check_word("VERSION", rd, `ELINK_VERSION);
      mi_read(cfg_addr(`ECFG_STATUS_OFS), rd);
      check_word("STATUS after reset", rd, 32'h0);
   endtask

   task automatic test_cfg_regs();
      logic [7:0]  ofs  [4];
      logic [31:0] mask [4];
      logic [31:0] wd   [4];
      logic [31:0] rd;
      ofs  = '{`ECFG_TX_OFS, `ECFG_RX_OFS, `ECFG_CLK_OFS, `ECFG_COREID_OFS};
      mask = '{32'h0000_0FF1, 32'h0000_0007, 32'h0000_0FF1, 32'h0000_0FFF};  // Defined bits
      foreach (wd[i]) begin
         wd[i] = $urandom;
         mi_write(cfg_addr(ofs[i]), wd[i]);
      end
      foreach (wd[i]) begin
         mi_read(cfg_addr(ofs[i]), rd);
         check_word($sformatf("readback of offset %h", ofs[i]), rd, wd[i] & mask[i]);
      end
      exp_ctrl.tx_enable    = wd[0][0];
      exp_ctrl.tx_ctrl_mode = wd[0][7:4];
      exp_ctrl.tx_clkdiv    = wd[0][11:8];
      exp_ctrl.rx_enable    = wd[1][0];
      exp_ctrl.rx_mmu_mode  = wd[1][1];
      exp_ctrl.rx_gpio_mode = wd[1][2];
      exp_ctrl.cclk_en      = wd[2][0];
      exp_ctrl.cclk_div     = wd[2][7:4];
      exp_ctrl.cclk_pllcfg  = wd[2][11:8];
      exp_ctrl.coreid       = wd[3][11:0];
      check_ctrl("ctrl after writes", ctrl, exp_ctrl);
      mi_write(cfg_addr(`ECFG_VERSION_OFS), $urandom);          // Read only
      mi_read(cfg_addr(`ECFG_VERSION_OFS), rd);
      check_word("VERSION after write", rd, `ELINK_VERSION);
   endtask

   task automatic test_mailbox_fifo();
      logic [63:0]  ent [`ELINK_MBOX_DEPTH+1];
      logic [31:0]  rd;
      mbox_status_t exp_st;
      for (int i = 0; i <= `ELINK_MBOX_DEPTH; i++) begin
         ent[i] = {$urandom, $urandom};
         push_entry(ent[i]);                                     // Last one overflows
         exp_st.full      = (i + 1 >= `ELINK_MBOX_DEPTH);
         exp_st.not_empty = 1'b1;
         check_status("flags while filling", flags, exp_st);
      end
      mi_read(cfg_addr(`ECFG_STATUS_OFS), rd);
      check_word("STATUS when full", rd, 32'h3);
      for (int i = 0; i < `ELINK_MBOX_DEPTH; i++) begin
         mi_read(mbox_addr(`EMBOX_LO_OFS), rd);                  // Peek
         check_word("mailbox low word", rd, ent[i][31:0]);
         mi_read(mbox_addr(`EMBOX_HI_OFS), rd);                  // Pop
         check_word("mailbox high word", rd, ent[i][63:32]);
         exp_st.full      = 1'b0;
         exp_st.not_empty = (i + 1 < `ELINK_MBOX_DEPTH);
         check_status("flags while draining", flags, exp_st);
         mi_read(cfg_addr(`ECFG_STATUS_OFS), rd);
         check_word("STATUS while draining", rd, {30'b0, exp_st.full, exp_st.not_empty});
      end
      mi_read(mbox_addr(`EMBOX_HI_OFS), rd);
      check_word("read of empty mailbox", rd, 32'h0);
      check_status("flags after empty read", flags, '0);
   endtask

   task automatic test_soft_reset();
      logic [31:0] rd;
      push_entry({$urandom, $urandom});
      push_entry({$urandom, $urandom});
      check_status("flags before soft reset", flags, '{full: 1'b0, not_empty: 1'b1});
      mi_write(cfg_addr(`ECFG_RESET_OFS), 32'h1);
      check_word("resetb_out in soft reset", 32'(resetb_out), 32'd0);
      check_status("flags in soft reset", flags, '0);
      mi_read(cfg_addr(`ECFG_RESET_OFS), rd);
      check_word("RESET readback", rd, 32'h1);
      push_entry({$urandom, $urandom});                          // Dropped
      check_status("flags after push in soft reset", flags, '0);
      mi_write(cfg_addr(`ECFG_RESET_OFS), 32'h0);
      check_word("resetb_out after soft reset", 32'(resetb_out), 32'd1);
      check_status("flags after soft reset", flags, '0);
      mi_read(mbox_addr(`EMBOX_LO_OFS), rd);
      check_word("mailbox after soft reset", rd, 32'h0);
   endtask

   task automatic test_back_to_back_reads();
      logic [`ELINK_RFAW-1:0] addr   [3];
      logic [31:0]            exp_rd [3];
      logic [31:0]            rd;
      addr   = '{cfg_addr(`ECFG_COREID_OFS), UNMAPPED_ADDR, cfg_addr(`ECFG_VERSION_OFS)};
      exp_rd = '{32'(exp_ctrl.coreid), 32'h0, `ELINK_VERSION};
      for (int i = 0; i <= 3; i++) begin
         @(negedge mi_clk);
         if (i > 0) begin                                        // Answer to the previous read
            check_word("rd_valid in burst", 32'(mi_rd_valid), 32'd1);
            check_word("burst read data", mi_rd_data, exp_rd[i-1]);
         end
         if (i < 3) begin
            mi_req = '{en: 1'b1, we: 1'b0, addr: addr[i], din: '0};
         end else begin
            mi_req = '0;
         end
      end
      @(negedge mi_clk);
      check_word("rd_valid after burst", 32'(mi_rd_valid), 32'd0);
      mi_write(UNMAPPED_ADDR, $urandom);
      mi_write({5'd3, `ECFG_TX_OFS}, $urandom);
      check_ctrl("ctrl after unmapped writes", ctrl, exp_ctrl);
      check_status("flags after unmapped writes", flags, '0);
      mi_read(UNMAPPED_ADDR, rd);
      check_word("unmapped read", rd, 32'h0);
      mi_read(cfg_addr(`ECFG_COREID_OFS), rd);
      check_word("COREID after unmapped writes", rd, 32'(exp_ctrl.coreid));
   endtask

   initial begin
      mi_clk = 1'b0;
      forever #5 mi_clk = ~mi_clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge mi_clk);
      $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      stop_with_failure();
   end

   initial begin
      void'($urandom(SEED));
      rst    = 1'b1;
      mi_req = '0;
      repeat (8) @(posedge mi_clk);
      @(negedge mi_clk);
      rst = 1'b0;
      test_reset_values();
      test_cfg_regs();
      test_mailbox_fifo();
      test_soft_reset();
      test_back_to_back_reads();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- verilog/elink_cfg_regs.sv
`include "elink_defs.svh"

module elink_cfg_regs
   import elink_pkg::*;
(
   input  logic                  mi_clk,
   input  logic                  rst,
   input  mi_req_t               cfg_req,         // Decoded config strobe
   input  mbox_status_t          mbox_status,     // Mailbox flags for STATUS
   output logic [`ELINK_DW-1:0]  cfg_rd_data,     // Comb read word
   output ecfg_ctrl_t            ctrl,            // Link control fields
   output logic                  cfg_soft_reset,  // Held while RESET[0] set
   output logic                  resetb_out       // Active low chip reset
);

   localparam ecfg_ctrl_t CTRL_RST = '{coreid: `ELINK_DEF_COREID, default: '0};

   ecfg_reg_e            reg_sel;                 // Offset of this access
   logic                 wr_en;
   logic [`ELINK_DW-1:0] din;
   ecfg_ctrl_t           ctrl_nxt;
   logic                 soft_reset_nxt;

   assign reg_sel = ecfg_reg_e'(cfg_req.addr[`ELINK_OFS_MSB:`ELINK_OFS_LSB]);
   assign wr_en   = cfg_req.en & cfg_req.we;
   assign din     = cfg_req.din;

   // Next state, only the defined fields are kept
   always_comb begin
      ctrl_nxt       = ctrl;
      soft_reset_nxt = cfg_soft_reset;
      if (wr_en) begin
         case (reg_sel)
            ECFG_RESET: soft_reset_nxt = din[0];
            ECFG_TX: begin
               ctrl_nxt.tx_enable    = din[0];
               ctrl_nxt.tx_ctrl_mode = din[7:4];
               ctrl_nxt.tx_clkdiv    = din[11:8];
            end
            ECFG_RX: begin
               ctrl_nxt.rx_enable    = din[0];
               ctrl_nxt.rx_mmu_mode  = din[1];
               ctrl_nxt.rx_gpio_mode = din[2];
            end
            ECFG_CLK: begin
               ctrl_nxt.cclk_en      = din[0];
               ctrl_nxt.cclk_div     = din[7:4];
               ctrl_nxt.cclk_pllcfg  = din[11:8];
            end
            ECFG_COREID: ctrl_nxt.coreid = din[`ELINK_COREID_W-1:0];
            default: ;                        // VERSION and STATUS are read only
         endcase
      end
   end

   always_ff @(posedge mi_clk) begin
      if (rst) begin
         ctrl           <= CTRL_RST;
         cfg_soft_reset <= 1'b0;
         resetb_out     <= 1'b1;              // Chip out of reset
      end else begin
         ctrl           <= ctrl_nxt;
         cfg_soft_reset <= soft_reset_nxt;
         resetb_out     <= ~soft_reset_nxt;  // Same edge as the soft reset bit
      end
   end

   // Readback of the register at the current offset
   always_comb begin
      cfg_rd_data = '0;
      case (reg_sel)
         ECFG_RESET: cfg_rd_data[0] = cfg_soft_reset;
         ECFG_TX: begin
            cfg_rd_data[0]    = ctrl.tx_enable;
            cfg_rd_data[7:4]  = ctrl.tx_ctrl_mode;
            cfg_rd_data[11:8] = ctrl.tx_clkdiv;
         end
         ECFG_RX: begin
            cfg_rd_data[0] = ctrl.rx_enable;
            cfg_rd_data[1] = ctrl.rx_mmu_mode;
            cfg_rd_data[2] = ctrl.rx_gpio_mode;
         end
         ECFG_CLK: begin
            cfg_rd_data[0]    = ctrl.cclk_en;
            cfg_rd_data[7:4]  = ctrl.cclk_div;
            cfg_rd_data[11:8] = ctrl.cclk_pllcfg;
         end
         ECFG_COREID:  cfg_rd_data[`ELINK_COREID_W-1:0] = ctrl.coreid;
         ECFG_VERSION: cfg_rd_data = `ELINK_VERSION;
         ECFG_STATUS: begin
            cfg_rd_data[0] = mbox_status.not_empty;
            cfg_rd_data[1] = mbox_status.full;
         end
         default: cfg_rd_data = '0;          // Holes read as zero
      endcase
   end

   // Chip reset must track the soft reset bit with no gap
   a_resetb_soft: assert property (@(posedge mi_clk) disable iff (rst)
      cfg_soft_reset |-> !resetb_out);

endmodule

//--- verilog/elink_defs.svh
`ifndef ELINK_DEFS_SVH
`define ELINK_DEFS_SVH

`define ELINK_DW          32                // Host data width
`define ELINK_RFAW        13                // Register address width
`define ELINK_COREID_W    12                // Core ID field width
`define ELINK_DEF_COREID  12'h810           // Core ID after reset
`define ELINK_VERSION     32'h0000_0101     // Fixed version word
`define ELINK_MBOX_DEPTH  4                 // Mailbox entries

`define ELINK_BLK_MSB     12                // Block select field
`define ELINK_BLK_LSB     8
`define ELINK_BLK_CFG     5'd0              // Config registers
`define ELINK_BLK_MBOX    5'd1              // Mailbox
`define ELINK_OFS_MSB     7                 // Word offset field
`define ELINK_OFS_LSB     2

`define ECFG_RESET_OFS    (8'h00)           // Byte offsets in config block
`define ECFG_TX_OFS       (8'h04)
`define ECFG_RX_OFS       (8'h08)
`define ECFG_CLK_OFS      (8'h0C)
`define ECFG_COREID_OFS   (8'h10)
`define ECFG_VERSION_OFS  (8'h14)
`define ECFG_STATUS_OFS   (8'h18)
`define EMBOX_LO_OFS      (8'h00)           // Byte offsets in mailbox block
`define EMBOX_HI_OFS      (8'h04)

`endif

//--- verilog/elink_mailbox.sv
`include "elink_defs.svh"

module elink_mailbox
   import elink_pkg::*;
(
   input  logic                  mi_clk,
   input  logic                  rst,
   input  logic                  cfg_soft_reset,  // Holds mailbox empty
   input  mi_req_t               mbox_req,        // Decoded mailbox strobe
   output logic [`ELINK_DW-1:0]  mbox_rd_data,    // Comb read word
   output mbox_status_t          mbox_status
);

   localparam int DEPTH = `ELINK_MBOX_DEPTH;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);

   logic [2*`ELINK_DW-1:0] mem [DEPTH];          // Entry storage
   logic [PW-1:0]          wr_ptr;
   logic [PW-1:0]          rd_ptr;
   logic [CW-1:0]          count;                // Entries held
   logic [`ELINK_DW-1:0]   hold_lo;              // Low half waiting for HI
   logic [2*`ELINK_DW-1:0] head;
   logic                   sel_lo;
   logic                   sel_hi;
   logic                   wr_acc;
   logic                   rd_acc;
   logic                   has_data;
   logic                   is_full;
   logic                   push;
   logic                   pop;

   function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
      if (p == PW'(DEPTH - 1)) begin
         return '0;                          // Wrap at the last entry
      end
      return p + 1'b1;
   endfunction

   assign sel_lo   = mbox_req.addr[`ELINK_OFS_MSB:`ELINK_OFS_LSB] == 6'(`EMBOX_LO_OFS >> 2);
   assign sel_hi   = mbox_req.addr[`ELINK_OFS_MSB:`ELINK_OFS_LSB] == 6'(`EMBOX_HI_OFS >> 2);
   assign wr_acc   = mbox_req.en & mbox_req.we & ~cfg_soft_reset;  // Writes dropped in reset
   assign rd_acc   = mbox_req.en & ~mbox_req.we;
   assign has_data = (count != '0) & ~cfg_soft_reset;              // Seen empty in reset
   assign is_full  = (count == CW'(DEPTH)) & ~cfg_soft_reset;
   assign push     = wr_acc & sel_hi & ~is_full;                   // Full drops the push
   assign pop      = rd_acc & sel_hi & has_data;                   // HI read consumes head
   assign head     = mem[rd_ptr];

   always_ff @(posedge mi_clk) begin
      if (rst || cfg_soft_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // Both or neither
         endcase
      end
   end

   always_ff @(posedge mi_clk) begin
      if (push) begin
         mem[wr_ptr] <= {mbox_req.din, hold_lo};
      end
      if (wr_acc && sel_lo) begin
         hold_lo <= mbox_req.din;
      end
   end

   // Head words, zero when empty
   always_comb begin
      mbox_rd_data = '0;
      if (has_data) begin
         if (sel_lo) begin
            mbox_rd_data = head[`ELINK_DW-1:0];
         end else if (sel_hi) begin
            mbox_rd_data = head[2*`ELINK_DW-1:`ELINK_DW];
         end
      end
   end

   assign mbox_status.full      = is_full;
   assign mbox_status.not_empty = has_data;

   a_count_max: assert property (@(posedge mi_clk) disable iff (rst)
      count <= CW'(DEPTH));

   // Held entries always show on a flag outside soft reset
   a_flags_cover: assert property (@(posedge mi_clk) disable iff (rst || cfg_soft_reset)
      (count != '0) |-> (mbox_status.full || mbox_status.not_empty));

endmodule

//--- verilog/elink_mi_decode.sv
`include "elink_defs.svh"

module elink_mi_decode
   import elink_pkg::*;
(
   input  logic                  mi_clk,
   input  logic                  rst,
   input  mi_req_t               mi_req,         // From host
   output mi_req_t               cfg_req,        // Strobe to config regs
   output mi_req_t               mbox_req,       // Strobe to mailbox
   input  logic [`ELINK_DW-1:0]  cfg_rd_data,    // Comb read word
   input  logic [`ELINK_DW-1:0]  mbox_rd_data,   // Comb read word
   output logic [`ELINK_DW-1:0]  mi_rd_data,     // One cycle after strobe
   output logic                  mi_rd_valid
);

   mi_blk_e              blk;                    // Block hit by this access
   logic                 rd_stb;                 // Read strobe
   logic [`ELINK_DW-1:0] rd_sel;                 // Word from the hit block

   always_comb begin
      case (mi_req.addr[`ELINK_BLK_MSB:`ELINK_BLK_LSB])
         `ELINK_BLK_CFG:  blk = BLK_CFG;
         `ELINK_BLK_MBOX: blk = BLK_MBOX;
         default:         blk = BLK_NONE;    // Unmapped space
      endcase
   end

   // Forward the access, strobe only to the hit block
   always_comb begin
      cfg_req     = mi_req;
      cfg_req.en  = mi_req.en & (blk == BLK_CFG);
      mbox_req    = mi_req;
      mbox_req.en = mi_req.en & (blk == BLK_MBOX);
   end

   assign rd_stb = mi_req.en & ~mi_req.we;

   always_comb begin
      case (blk)
         BLK_CFG:  rd_sel = cfg_rd_data;
         BLK_MBOX: rd_sel = mbox_rd_data;
         default:  rd_sel = '0;              // Unmapped reads as zero
      endcase
   end

   always_ff @(posedge mi_clk) begin
      if (rst) begin
         mi_rd_valid <= 1'b0;
      end else begin
         mi_rd_valid <= rd_stb;              // Fixed one-cycle latency
      end
   end

   always_ff @(posedge mi_clk) begin
      if (rd_stb) begin
         mi_rd_data <= rd_sel;               // Capture at the read edge
      end
   end

   // Every read answers exactly one cycle later, and nothing else does
   a_rd_latency: assert property (@(posedge mi_clk) disable iff (rst)
      !$past(rst) |-> (mi_rd_valid == $past(mi_req.en && !mi_req.we)));

endmodule

//--- verilog/elink_pkg.sv
`include "elink_defs.svh"

package elink_pkg;

   // One host access on the mi bus
   typedef struct packed {
      logic                    en;          // Access strobe
      logic                    we;          // 1 write, 0 read
      logic [`ELINK_RFAW-1:0]  addr;        // Byte address
      logic [`ELINK_DW-1:0]    din;         // Write data
   } mi_req_t;

   typedef enum logic [1:0] {
      BLK_CFG  = 2'd0,                      // Config register file
      BLK_MBOX = 2'd1,                      // Mailbox
      BLK_NONE = 2'd2                       // Unmapped
   } mi_blk_e;

   // Word offsets of the config registers
   typedef enum logic [5:0] {
      ECFG_RESET   = 6'(`ECFG_RESET_OFS >> 2),
      ECFG_TX      = 6'(`ECFG_TX_OFS >> 2),
      ECFG_RX      = 6'(`ECFG_RX_OFS >> 2),
      ECFG_CLK     = 6'(`ECFG_CLK_OFS >> 2),
      ECFG_COREID  = 6'(`ECFG_COREID_OFS >> 2),
      ECFG_VERSION = 6'(`ECFG_VERSION_OFS >> 2),
      ECFG_STATUS  = 6'(`ECFG_STATUS_OFS >> 2)
   } ecfg_reg_e;

   typedef struct packed {
      logic                       tx_enable;     // TX[0]
      logic [3:0]                 tx_ctrl_mode;  // TX[7:4]
      logic [3:0]                 tx_clkdiv;     // TX[11:8]
      logic                       rx_enable;     // RX[0]
      logic                       rx_mmu_mode;   // RX[1]
      logic                       rx_gpio_mode;  // RX[2]
      logic                       cclk_en;       // CLK[0]
      logic [3:0]                 cclk_div;      // CLK[7:4]
      logic [3:0]                 cclk_pllcfg;   // CLK[11:8]
      logic [`ELINK_COREID_W-1:0] coreid;        // COREID[11:0]
   } ecfg_ctrl_t;

   typedef struct packed {
      logic full;                           // No room for a push
      logic not_empty;                      // Head entry valid
   } mbox_status_t;

endpackage

//--- verilog/elink_top.sv
`include "elink_defs.svh"

module elink_top
   import elink_pkg::*;
(
   input  logic                  mi_clk,          // Single clock domain
   input  logic                  rst,
   input  mi_req_t               mi_req,          // Host access
   output logic [`ELINK_DW-1:0]  mi_rd_data,
   output logic                  mi_rd_valid,
   output ecfg_ctrl_t            ctrl,            // TX, RX and clock fields
   output logic                  resetb_out,
   output logic                  embox_full,
   output logic                  embox_not_empty
);

   mi_req_t              cfg_req;
   mi_req_t              mbox_req;
   logic [`ELINK_DW-1:0] cfg_rd_data;
   logic [`ELINK_DW-1:0] mbox_rd_data;
   logic                 cfg_soft_reset;
   mbox_status_t         mbox_status;

   elink_mi_decode i_mi_decode (
      .mi_clk       (mi_clk),
      .rst          (rst),
      .mi_req       (mi_req),
      .cfg_req      (cfg_req),
      .mbox_req     (mbox_req),
      .cfg_rd_data  (cfg_rd_data),
      .mbox_rd_data (mbox_rd_data),
      .mi_rd_data   (mi_rd_data),
      .mi_rd_valid  (mi_rd_valid)
   );

   elink_cfg_regs i_cfg_regs (
      .mi_clk         (mi_clk),
      .rst            (rst),
      .cfg_req        (cfg_req),
      .mbox_status    (mbox_status),   // Feeds STATUS readback
      .cfg_rd_data    (cfg_rd_data),
      .ctrl           (ctrl),
      .cfg_soft_reset (cfg_soft_reset),
      .resetb_out     (resetb_out)
   );

   elink_mailbox i_mailbox (
      .mi_clk         (mi_clk),
      .rst            (rst),
      .cfg_soft_reset (cfg_soft_reset),
      .mbox_req       (mbox_req),
      .mbox_rd_data   (mbox_rd_data),
      .mbox_status    (mbox_status)
   );

   assign embox_full      = mbox_status.full;       // Flag pins
   assign embox_not_empty = mbox_status.not_empty;

endmodule
